// File: rtl/video_pkg.sv
package video_pkg;

   ////////////////////////////////////////
   // Video memory layout
   ////////////////////////////////////////

   localparam int vram_addr_w = 13;
   localparam int vram_depth = 1 << vram_addr_w;
   localparam int font_base_w = 2;
   localparam logic [vram_addr_w-1:0] text_base = 13'h1e00; // Text rows, one byte per cell.

   localparam int cell_px = 8;
   localparam int cell_w = $clog2(cell_px);

   localparam int pal_entries = 16;
   localparam int pal_idx_w = 4;
   localparam int rgb_w = 16;

   ////////////////////////////////////////
   // CPU register map
   ////////////////////////////////////////

   localparam int axi_addr_w = 8;
   localparam int axi_data_w = 32;
   localparam int reg_idx_w = axi_addr_w - 2; // Byte address divided by 4.

   localparam logic [reg_idx_w-1:0] reg_mem_addr = 6'd0;
   localparam logic [reg_idx_w-1:0] reg_mem_data = 6'd1;
   localparam logic [reg_idx_w-1:0] reg_pal_index = 6'd2;
   localparam logic [reg_idx_w-1:0] reg_pal_data = 6'd3;
   localparam logic [reg_idx_w-1:0] reg_font_base = 6'd4;
   localparam logic [reg_idx_w-1:0] reg_control = 6'd5;

endpackage

// File: rtl/cpu_regs.sv
`timescale 1ns/1ps

module cpu_regs (
   input  logic                                 sys_clk,
   input  logic                                 rst,
   input  logic                                 awvalid,
   input  logic [video_pkg::axi_addr_w-1:0]     awaddr,
   input  logic                                 wvalid,
   input  logic [video_pkg::axi_data_w-1:0]     wdata,
   input  logic                                 bready,
   output logic                                 awready,
   output logic                                 wready,
   output logic                                 bvalid,
   output logic [1:0]                           bresp,
   input  logic                                 arvalid,
   input  logic [video_pkg::axi_addr_w-1:0]     araddr,
   input  logic                                 rready,
   output logic                                 arready,
   output logic                                 rvalid,
   output logic [video_pkg::axi_data_w-1:0]     rdata,
   output logic [1:0]                           rresp,
   output logic                                 cpu_req,
   output logic                                 cpu_we,
   output logic [video_pkg::vram_addr_w-1:0]    cpu_addr,
   output logic [7:0]                           cpu_wdata,
   input  logic                                 cpu_ack,
   input  logic [7:0]                           cpu_rdata,
   output logic                                 pal_we,
   output logic [video_pkg::pal_idx_w-1:0]      pal_idx,
   output logic [video_pkg::rgb_w-1:0]          pal_rgb,
   output logic [video_pkg::font_base_w-1:0]    font_base,
   output logic                                 display_en
);
   import video_pkg::*;

   logic [vram_addr_w-1:0] mem_ptr;
   logic [7:0] pal_lo;
   logic pal_hi;
   logic wr_go;
   logic rd_go;
   logic [reg_idx_w-1:0] wr_reg;
   logic [reg_idx_w-1:0] rd_reg;

   // One transaction at a time; a pending memory access or response blocks both channels.
   assign wr_go = awvalid && wvalid && !cpu_req && !bvalid && !rvalid;
   assign rd_go = arvalid && !wr_go && !cpu_req && !bvalid && !rvalid;
   assign awready = wr_go;
   assign wready = wr_go;
   assign arready = rd_go;
   assign wr_reg = awaddr[axi_addr_w-1:2];
   assign rd_reg = araddr[axi_addr_w-1:2];
   assign bresp = 2'b00;
   assign rresp = 2'b00;
   assign cpu_addr = mem_ptr; // The pointer only moves on cpu_ack.

   always_ff @(posedge sys_clk) begin
      pal_we <= 1'b0;
      if (rst) begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
         cpu_req <= 1'b0;
         mem_ptr <= '0;
         pal_idx <= '0;
         pal_hi <= 1'b0;
         font_base <= '0;
         display_en <= 1'b0;
      end else begin
         if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
         end
         if (pal_we) begin
            pal_idx <= pal_idx + 1'b1; // Index steps after each committed entry.
         end

         if (cpu_ack) begin
            cpu_req <= 1'b0;
            mem_ptr <= mem_ptr + 1'b1;
            if (cpu_we) begin
               bvalid <= 1'b1;
            end else begin
               rvalid <= 1'b1;
               rdata <= axi_data_w'(cpu_rdata);
            end
         end

         if (wr_go) begin
            case (wr_reg)
               reg_mem_addr: mem_ptr <= wdata[vram_addr_w-1:0];
               reg_mem_data: begin
                  cpu_req <= 1'b1;
                  cpu_we <= 1'b1;
                  cpu_wdata <= wdata[7:0];
               end
               reg_pal_index: begin
                  pal_idx <= wdata[pal_idx_w-1:0];
                  pal_hi <= 1'b0;
               end
               reg_pal_data: begin
                  if (pal_hi) begin
                     pal_we <= 1'b1;
                     pal_rgb <= {wdata[7:0], pal_lo};
                  end else begin
                     pal_lo <= wdata[7:0];
                  end
                  pal_hi <= !pal_hi;
               end
               reg_font_base: font_base <= wdata[font_base_w-1:0];
               reg_control: display_en <= wdata[0];
               default: ;
            endcase
            if (wr_reg != reg_mem_data) begin
               bvalid <= 1'b1;
            end
         end

         if (rd_go) begin
            if (rd_reg == reg_mem_data) begin
               cpu_req <= 1'b1;
               cpu_we <= 1'b0;
            end else begin
               rvalid <= 1'b1;
               case (rd_reg)
                  reg_mem_addr: rdata <= axi_data_w'(mem_ptr);
                  reg_pal_index: rdata <= axi_data_w'(pal_idx);
                  reg_font_base: rdata <= axi_data_w'(font_base);
                  reg_control: rdata <= axi_data_w'(display_en);
                  default: rdata <= '0;
               endcase
            end
         end
      end
   end

endmodule

// File: rtl/vram_arbiter.sv
`timescale 1ns/1ps

module vram_arbiter (
   input  logic                              sys_clk,
   input  logic                              rst,
   input  logic                              fetch_req,
   input  logic [video_pkg::vram_addr_w-1:0] fetch_addr,
   output logic                              fetch_ack,
   output logic [7:0]                        fetch_rdata,
   input  logic                              cpu_req,
   input  logic                              cpu_we,
   input  logic [video_pkg::vram_addr_w-1:0] cpu_addr,
   input  logic [7:0]                        cpu_wdata,
   output logic                              cpu_ack,
   output logic [7:0]                        cpu_rdata,
   output logic                              ram_en,
   output logic                              ram_we,
   output logic [video_pkg::vram_addr_w-1:0] ram_addr,
   output logic [7:0]                        ram_wdata,
   input  logic [7:0]                        ram_rdata
);

   logic idle;
   logic gnt_fetch;
   logic gnt_cpu;

   // No grant while an ack is out, so each access is grant cycle plus ack cycle.
   assign idle = !fetch_ack && !cpu_ack;
   assign gnt_fetch = idle && fetch_req;
   assign gnt_cpu = idle && !fetch_req && cpu_req; // Fetcher always wins.

   assign ram_en = gnt_fetch || gnt_cpu;
   assign ram_we = gnt_cpu && cpu_we;
   assign ram_addr = gnt_fetch ? fetch_addr : cpu_addr;
   assign ram_wdata = cpu_wdata;

   assign fetch_rdata = fetch_ack ? ram_rdata : 8'h00;
   assign cpu_rdata = cpu_ack ? ram_rdata : 8'h00;

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         fetch_ack <= 1'b0;
         cpu_ack <= 1'b0;
      end else begin
         fetch_ack <= gnt_fetch;
         cpu_ack <= gnt_cpu;
      end
   end

endmodule

// File: rtl/video_ram.sv
`timescale 1ns/1ps

module video_ram (
   input  logic                              sys_clk,
   input  logic                              en,
   input  logic                              we,
   input  logic [video_pkg::vram_addr_w-1:0] addr,
   input  logic [7:0]                        wdata,
   output logic [7:0]                        rdata
);
   import video_pkg::*;

   logic [7:0] mem [vram_depth];

   always_ff @(posedge sys_clk) begin
      if (en) begin
         if (we) begin
            mem[addr] <= wdata;
         end
         rdata <= mem[addr]; // Old contents on a write cycle.
      end
   end

endmodule

// File: rtl/char_fetch.sv
`timescale 1ns/1ps

module char_fetch #(
   parameter int text_cols = 80,
   parameter int text_rows = 30
) (
   input  logic                                              sys_clk,
   input  logic                                              rst,
   input  logic                                              line_start,
   input  logic [$clog2(text_rows*video_pkg::cell_px)-1:0]   fetch_line,
   input  logic                                              fetch_half,
   input  logic [video_pkg::font_base_w-1:0]                 font_base,
   output logic                                              fetch_req,
   output logic [video_pkg::vram_addr_w-1:0]                 fetch_addr,
   input  logic                                              fetch_ack,
   input  logic [7:0]                                        fetch_rdata,
   output logic                                              wr_en,
   output logic                                              wr_half,
   output logic [$clog2(text_cols*video_pkg::cell_px)-1:0]   wr_addr,
   output logic [7:0]                                        wr_bits,
   output logic                                              busy
);
   import video_pkg::*;

   localparam int col_w = $clog2(text_cols);
   localparam logic [col_w-1:0] last_col = col_w'(text_cols - 1);

   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_text = 2'd1;
   localparam logic [1:0] st_font = 2'd2;

   logic [1:0] state;
   logic [col_w-1:0] col;
   logic [cell_w-1:0] scan;
   logic half;
   logic [font_base_w-1:0] fb;
   logic [vram_addr_w-1:0] row_addr;
   logic [7:0] codes [text_cols]; // Character codes of the current text row.

   assign busy = (state != st_idle);

   // Address is held steady while the request waits for its ack.
   assign fetch_addr = (state == st_text) ? row_addr + vram_addr_w'(col)
                                          : {fb, codes[col], scan};

   always_ff @(posedge sys_clk) begin
      wr_en <= 1'b0;
      if (rst) begin
         state <= st_idle;
         fetch_req <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (line_start) begin
                  scan <= fetch_line[cell_w-1:0];
                  half <= fetch_half;
                  fb <= font_base;
                  row_addr <= text_base
                     + vram_addr_w'(fetch_line >> cell_w) * vram_addr_w'(text_cols);
                  col <= '0;
                  // Codes are only read on the first scan row of a text row.
                  state <= (fetch_line[cell_w-1:0] == '0) ? st_text : st_font;
               end
            end
            st_text: begin
               if (fetch_ack) begin
                  fetch_req <= 1'b0;
                  codes[col] <= fetch_rdata;
                  if (col == last_col) begin
                     col <= '0;
                     state <= st_font;
                  end else begin
                     col <= col + 1'b1;
                  end
               end else begin
                  fetch_req <= 1'b1;
               end
            end
            st_font: begin
               if (fetch_ack) begin
                  fetch_req <= 1'b0;
                  wr_en <= 1'b1;
                  wr_half <= half;
                  wr_addr <= {col, {cell_w{1'b0}}};
                  wr_bits <= fetch_rdata;
                  if (col == last_col) begin
                     state <= st_idle;
                  end else begin
                     col <= col + 1'b1;
                  end
               end else begin
                  fetch_req <= 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

// File: rtl/line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
   parameter int text_cols = 80
) (
   input  logic                                              sys_clk,
   input  logic                                              wr_en,
   input  logic                                              wr_half,
   input  logic [$clog2(text_cols*video_pkg::cell_px)-1:0]   wr_addr,
   input  logic [7:0]                                        wr_bits,
   input  logic                                              rd_half,
   input  logic [$clog2(text_cols*video_pkg::cell_px)-1:0]   rd_addr,
   output logic [video_pkg::pal_idx_w-1:0]                   rd_pix
);
   import video_pkg::*;

   localparam int act_w = text_cols * cell_px;

   // Only palette entries 0 and 1 are ever used, so one bit per pixel is enough.
   logic pix [2][act_w];

   always_ff @(posedge sys_clk) begin
      if (wr_en) begin
         for (int i = 0; i < cell_px; i++) begin
            pix[wr_half][wr_addr + i] <= wr_bits[cell_px - 1 - i]; // Leftmost pixel is the MSB.
         end
      end
      rd_pix <= pal_idx_w'(pix[rd_half][rd_addr]);
   end

endmodule

// File: rtl/scan_gen.sv
`timescale 1ns/1ps

module scan_gen #(
   parameter int text_cols = 80,
   parameter int text_rows = 30,
   parameter int h_blank = 160,
   parameter int v_blank = 45
) (
   input  logic                                              sys_clk,
   input  logic                                              rst,
   input  logic                                              display_en,
   input  logic                                              pal_we,
   input  logic [video_pkg::pal_idx_w-1:0]                   pal_idx,
   input  logic [video_pkg::rgb_w-1:0]                       pal_rgb,
   output logic                                              line_start,
   output logic [$clog2(text_rows*video_pkg::cell_px)-1:0]   fetch_line,
   output logic                                              fetch_half,
   output logic                                              rd_half,
   output logic [$clog2(text_cols*video_pkg::cell_px)-1:0]   rd_addr,
   input  logic [video_pkg::pal_idx_w-1:0]                   rd_pix,
   output logic                                              hs,
   output logic                                              vs,
   output logic                                              de,
   output logic [4:0]                                        red,
   output logic [5:0]                                        green,
   output logic [4:0]                                        blue
);
   import video_pkg::*;

   localparam int act_w = text_cols * cell_px;
   localparam int act_h = text_rows * cell_px;
   localparam int h_total = act_w + h_blank;
   localparam int v_total = act_h + v_blank;
   localparam int hc_w = $clog2(h_total);
   localparam int vc_w = $clog2(v_total);

   logic [hc_w-1:0] hc;
   logic [vc_w-1:0] vc;
   logic [vc_w-1:0] next_line;
   logic [vc_w-1:0] prep_line;
   logic active;
   logic hs_raw;
   logic vs_raw;
   logic de1;
   logic hs1;
   logic vs1;
   logic [rgb_w-1:0] pal [pal_entries];
   logic [rgb_w-1:0] rgb;

   assign active = (hc < act_w) && (vc < act_h);
   assign hs_raw = (hc >= act_w) && (hc < act_w + h_blank / 4);
   assign vs_raw = (vc >= act_h) && (vc < act_h + 2);

   // The fetch started in this line's blanking fills the line after next.
   assign next_line = (vc == vc_w'(v_total - 1)) ? '0 : vc + 1'b1;
   assign prep_line = (next_line == vc_w'(v_total - 1)) ? '0 : next_line + 1'b1;
   assign fetch_line = $bits(fetch_line)'(prep_line);
   assign fetch_half = prep_line[0];

   // Each line number owns the half given by its low bit.
   assign rd_half = vc[0];
   assign rd_addr = active ? hc[$bits(rd_addr)-1:0] : '0;

   ////////////////////////////////////////
   // Raster counters and output pipeline
   ////////////////////////////////////////

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         hc <= '0;
         vc <= '0;
         line_start <= 1'b0;
         de1 <= 1'b0;
         hs1 <= 1'b0;
         vs1 <= 1'b0;
         de <= 1'b0;
         hs <= 1'b0;
         vs <= 1'b0;
         rgb <= '0;
      end else begin
         if (hc == hc_w'(h_total - 1)) begin
            hc <= '0;
            vc <= next_line;
         end else begin
            hc <= hc + 1'b1;
         end
         line_start <= (hc == hc_w'(act_w - 1)) && (prep_line < act_h);

         de1 <= active; // Line buffer data lands with this stage.
         hs1 <= hs_raw;
         vs1 <= vs_raw;
         de <= de1;
         hs <= hs1;
         vs <= vs1;
         rgb <= (de1 && display_en) ? pal[rd_pix] : '0;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (pal_we) begin
         pal[pal_idx] <= pal_rgb;
      end
   end

   assign red = rgb[15:11];
   assign green = rgb[10:5];
   assign blue = rgb[4:0];

endmodule

// File: rtl/text_video_top.sv
`timescale 1ns/1ps

module text_video_top #(
   parameter int text_cols = 80,
   parameter int text_rows = 30,
   parameter int h_blank = 160,
   parameter int v_blank = 45
) (
   input  logic                             sys_clk,
   input  logic                             rst,
   input  logic                             awvalid,
   input  logic [video_pkg::axi_addr_w-1:0] awaddr,
   input  logic                             wvalid,
   input  logic [video_pkg::axi_data_w-1:0] wdata,
   input  logic                             bready,
   output logic                             awready,
   output logic                             wready,
   output logic                             bvalid,
   output logic [1:0]                       bresp,
   input  logic                             arvalid,
   input  logic [video_pkg::axi_addr_w-1:0] araddr,
   input  logic                             rready,
   output logic                             arready,
   output logic                             rvalid,
   output logic [video_pkg::axi_data_w-1:0] rdata,
   output logic [1:0]                       rresp,
   output logic                             hs,
   output logic                             vs,
   output logic                             de,
   output logic [4:0]                       red,
   output logic [5:0]                       green,
   output logic [4:0]                       blue
);
   import video_pkg::*;

   localparam int x_w = $clog2(text_cols * cell_px);
   localparam int line_w = $clog2(text_rows * cell_px);

   logic cpu_req, cpu_we, cpu_ack;
   logic [vram_addr_w-1:0] cpu_addr;
   logic [7:0] cpu_wdata, cpu_rdata;
   logic fetch_req, fetch_ack;
   logic [vram_addr_w-1:0] fetch_addr;
   logic [7:0] fetch_rdata;
   logic ram_en, ram_we;
   logic [vram_addr_w-1:0] ram_addr;
   logic [7:0] ram_wdata, ram_rdata;
   logic pal_we;
   logic [pal_idx_w-1:0] pal_idx, rd_pix;
   logic [rgb_w-1:0] pal_rgb;
   logic [font_base_w-1:0] font_base;
   logic display_en;
   logic line_start, fetch_half;
   logic [line_w-1:0] fetch_line;
   logic wr_en, wr_half, rd_half;
   logic [x_w-1:0] wr_addr, rd_addr;
   logic [7:0] wr_bits;

   cpu_regs cpu_regs_inst (.*);

   vram_arbiter vram_arbiter_inst (.*);

   video_ram video_ram_inst (
      .sys_clk (sys_clk),
      .en      (ram_en),
      .we      (ram_we),
      .addr    (ram_addr),
      .wdata   (ram_wdata),
      .rdata   (ram_rdata)
   );

   char_fetch #(
      .text_cols (text_cols),
      .text_rows (text_rows)
   ) char_fetch_inst (
      .busy (),
      .*
   );

   line_buffer #(
      .text_cols (text_cols)
   ) line_buffer_inst (.*);

   scan_gen #(
      .text_cols (text_cols),
      .text_rows (text_rows),
      .h_blank   (h_blank),
      .v_blank   (v_blank)
   ) scan_gen_inst (.*);

endmodule

// File: sim/tb_text_video.sv
`timescale 1ns/1ps

module tb_text_video;
   import video_pkg::*;

   localparam int text_cols = 4;
   localparam int text_rows = 2;
   localparam int h_blank = 96;
   localparam int v_blank = 6;
   localparam int act_w = text_cols * cell_px;
   localparam int act_h = text_rows * cell_px;
   localparam int h_total = act_w + h_blank;
   localparam int frame_cycles = h_total * (act_h + v_blank);
   localparam int axi_limit = 2 * h_total;

   logic sys_clk = 1'b0;
   logic rst;
   logic awvalid, wvalid, bready, awready, wready, bvalid;
   logic arvalid, rready, arready, rvalid;
   logic [axi_addr_w-1:0] awaddr, araddr;
   logic [axi_data_w-1:0] wdata, rdata;
   logic [1:0] bresp, rresp;
   logic hs, vs, de;
   logic [4:0] red, blue;
   logic [5:0] green;

   // Reference model of the video memory, palette and settings.
   logic [7:0] mem_model [vram_depth];
   logic [rgb_w-1:0] pal_model [pal_entries];
   logic [font_base_w-1:0] font_base_model;
   logic en_model;
   int model_ptr;
   logic [rgb_w-1:0] pix_cap [act_w * act_h];

   integer seed;
   int errors;
   int checks;
   int tests_failed;
   int test_errors;

   text_video_top #(
      .text_cols (text_cols),
      .text_rows (text_rows),
      .h_blank   (h_blank),
      .v_blank   (v_blank)
   ) text_video_top_inst (.*);

   always #4 sys_clk = ~sys_clk;

   ////////////////////////////////////////
   // Checking and reporting
   ////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out while waiting for %s.", what);
      $display("TESTBENCH FAILED");
      $finish;
   endtask

   task automatic end_test(input int num, input string name);
      if (errors == test_errors) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", num, name, errors - test_errors);
      end
      test_errors = errors;
   endtask

   function automatic logic [rgb_w-1:0] expected_rgb(input int x, input int y);
      logic [7:0] code;
      logic [7:0] bits;
      code = mem_model[text_base + (y / cell_px) * text_cols + x / cell_px];
      bits = mem_model[{font_base_model, code, 3'(y % cell_px)}];
      if (!en_model) begin
         return '0;
      end
      return bits[cell_px - 1 - x % cell_px] ? pal_model[1] : pal_model[0]; // MSB is leftmost.
   endfunction

   ////////////////////////////////////////
   // AXI4-Lite driver
   ////////////////////////////////////////

   task automatic axi_write(input logic [reg_idx_w-1:0] idx, input logic [31:0] data);
      int n;
      @(posedge sys_clk);
      awvalid <= 1'b1;
      awaddr <= {idx, 2'b00};
      wvalid <= 1'b1;
      wdata <= data;
      bready <= 1'b1;
      n = 0;
      do begin
         @(negedge sys_clk);
         n++;
         if (n > axi_limit) report_timeout("the write address and data to be accepted");
      end while (!(awready && wready));
      @(posedge sys_clk);
      awvalid <= 1'b0;
      wvalid <= 1'b0;
      n = 0;
      do begin
         @(negedge sys_clk);
         n++;
         if (n > axi_limit) report_timeout("the write response");
      end while (!bvalid);
      check_value("bresp", bresp, 0);
      @(posedge sys_clk);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [reg_idx_w-1:0] idx, output logic [31:0] data);
      int n;
      @(posedge sys_clk);
      arvalid <= 1'b1;
      araddr <= {idx, 2'b00};
      rready <= 1'b1;
      n = 0;
      do begin
         @(negedge sys_clk);
         n++;
         if (n > axi_limit) report_timeout("the read address to be accepted");
      end while (!arready);
      @(posedge sys_clk);
      arvalid <= 1'b0;
      n = 0;
      do begin
         @(negedge sys_clk);
         n++;
         if (n > axi_limit) report_timeout("the read data");
      end while (!rvalid);
      data = rdata;
      check_value("rresp", rresp, 0);
      @(posedge sys_clk);
      rready <= 1'b0;
   endtask

   task automatic set_pointer(input logic [vram_addr_w-1:0] addr);
      axi_write(reg_mem_addr, addr);
      model_ptr = addr;
   endtask

   task automatic write_byte(input logic [7:0] data);
      axi_write(reg_mem_data, data);
      mem_model[model_ptr] = data;
      model_ptr = (model_ptr + 1) % vram_depth; // Pointer wraps like the 13-bit register.
   endtask

   task automatic read_byte_check();
      logic [31:0] d;
      axi_read(reg_mem_data, d);
      check_value($sformatf("vram[%h]", model_ptr), d, mem_model[model_ptr]);
      model_ptr = (model_ptr + 1) % vram_depth;
   endtask

   // Random glyph rows for every code in the text area.
   task automatic load_font(input logic [font_base_w-1:0] base);
      logic [7:0] code;
      for (int i = 0; i < text_cols * text_rows; i++) begin
         code = mem_model[text_base + i];
         set_pointer({base, code, 3'b000});
         repeat (cell_px) write_byte(8'($random(seed)));
      end
   endtask

   ////////////////////////////////////////
   // Video capture
   ////////////////////////////////////////

   task automatic wait_vsync_end();
      int n;
      n = 0;
      do begin
         @(negedge sys_clk);
         n++;
         if (n > 2 * frame_cycles) report_timeout("vsync to start");
      end while (vs !== 1'b1);
      n = 0;
      do begin
         @(negedge sys_clk);
         n++;
         if (n > 2 * frame_cycles) report_timeout("vsync to end");
      end while (vs !== 1'b0);
   endtask

   task automatic wait_for_de();
      int n;
      n = 0;
      do begin
         @(negedge sys_clk);
         n++;
         if (n > 2 * frame_cycles) report_timeout("the active area");
      end while (de !== 1'b1);
   endtask

   task automatic capture_frame();
      int x;
      int y;
      int n;
      wait_vsync_end();
      x = 0;
      y = 0;
      n = 0;
      while (y < act_h) begin
         @(negedge sys_clk);
         n++;
         if (n > 8 * h_total) report_timeout("the next display line");
         if (de) begin
            if (x < act_w) begin
               pix_cap[y * act_w + x] = {red, green, blue};
            end
            x++;
         end else if (x != 0) begin
            check_value("pixels per line", x, act_w);
            x = 0;
            y++;
            n = 0;
         end
      end
   endtask

   task automatic compare_frame();
      for (int y = 0; y < act_h; y++) begin
         for (int x = 0; x < act_w; x++) begin
            check_value($sformatf("rgb at x %0d y %0d", x, y), pix_cap[y * act_w + x],
                        expected_rgb(x, y));
         end
      end
   endtask

   task automatic measure_timing();
      int n;
      int lines;
      int last_hs;
      logic hs_q;
      logic vs_q;
      logic done;
      n = 0;
      do begin
         @(negedge sys_clk);
         n++;
         if (n > 2 * frame_cycles) report_timeout("vsync to go low");
      end while (vs !== 1'b0);
      n = 0;
      do begin
         @(negedge sys_clk);
         n++;
         if (n > 2 * frame_cycles) report_timeout("vsync to rise");
      end while (vs !== 1'b1);
      n = 0;
      lines = 0;
      last_hs = -1;
      hs_q = hs;
      vs_q = vs;
      done = 1'b0;
      while (!done) begin
         @(negedge sys_clk);
         n++;
         if (n > 2 * frame_cycles) report_timeout("the following vsync");
         if (hs && !hs_q) begin
            if (last_hs >= 0) begin
               check_value("cycles per line", n - last_hs, h_total);
            end
            last_hs = n;
            lines++;
         end
         done = vs && !vs_q;
         hs_q = hs;
         vs_q = vs;
      end
      check_value("cycles per frame", n, frame_cycles);
      check_value("lines per frame", lines, act_h + v_blank);
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      logic [31:0] d;
      logic [rgb_w-1:0] rgb;
      int starts [4];
      int start;
      seed = 54;
      errors = 0;
      checks = 0;
      tests_failed = 0;
      test_errors = 0;
      en_model = 1'b0;
      font_base_model = '0;
      model_ptr = 0;
      rst <= 1'b1;
      awvalid <= 1'b0;
      awaddr <= '0;
      wvalid <= 1'b0;
      wdata <= '0;
      bready <= 1'b0;
      arvalid <= 1'b0;
      araddr <= '0;
      rready <= 1'b0;
      repeat (10) @(posedge sys_clk);
      rst <= 1'b0;

      @(negedge sys_clk);
      check_value("hs", hs, 0);
      check_value("vs", vs, 0);
      check_value("de", de, 0);
      repeat (frame_cycles) begin
         @(negedge sys_clk);
         check_value("rgb", {red, green, blue}, 0);
      end
      end_test(1, "reset and disabled display");

      for (int b = 0; b < 4; b++) begin
         starts[b] = $random(seed) & 32'h1fff;
         set_pointer(starts[b]);
         repeat (4) write_byte(8'($random(seed)));
      end
      for (int b = 0; b < 4; b++) begin
         set_pointer(starts[b]);
         repeat (4) read_byte_check();
         axi_read(reg_mem_addr, d);
         check_value("mem_addr", d, (starts[b] + 4) % vram_depth);
      end
      end_test(2, "memory write and readback");

      // Text and base 1 glyphs go in before the palette and the enable.
      set_pointer(text_base);
      repeat (text_cols * text_rows) write_byte(8'($random(seed)));
      load_font(2'd1);
      axi_write(reg_font_base, 1);
      font_base_model = 2'd1;

      axi_write(reg_pal_index, 0);
      for (int i = 0; i < 2; i++) begin
         rgb = 16'($random(seed));
         if (i == 1 && rgb == pal_model[0]) begin
            rgb = ~rgb; // Keeps lit and dark pixels apart.
         end
         axi_write(reg_pal_data, rgb[7:0]);
         axi_write(reg_pal_data, rgb[15:8]);
         pal_model[i] = rgb;
      end
      axi_write(reg_control, 1);
      en_model = 1'b1;
      capture_frame();
      for (int i = 0; i < act_w * act_h; i++) begin
         rgb = pix_cap[i];
         check_value("rgb palette entry", rgb,
                     (rgb === pal_model[1]) ? pal_model[1] : pal_model[0]);
      end
      end_test(3, "palette sequencing");
      compare_frame();
      end_test(4, "full frame with font base 1");

      load_font(2'd2);
      axi_write(reg_font_base, 2);
      font_base_model = 2'd2;
      capture_frame();
      compare_frame();
      end_test(5, "font base switch");

      // Base 0 is not on screen, so these writes only compete for the memory.
      start = $random(seed) & 32'h7f0;
      fork
         capture_frame();
         begin
            wait_vsync_end();
            wait_for_de();
            set_pointer(start);
            repeat (12) write_byte(8'($random(seed)));
         end
      join
      compare_frame();
      set_pointer(start);
      repeat (12) read_byte_check();
      measure_timing();
      end_test(6, "contention and sync timing");

      $display("6 tests run, %0d failed, %0d checks, %0d errors", tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: flist.f
rtl/video_pkg.sv
rtl/cpu_regs.sv
rtl/vram_arbiter.sv
rtl/video_ram.sv
rtl/char_fetch.sv
rtl/line_buffer.sv
rtl/scan_gen.sv
rtl/text_video_top.sv
sim/tb_text_video.sv
